// ==== aximm_link_defs.svh ====
/*
 * AXI-MM link parameters
 * field widths, receive FIFO depth and credit sizing
 */
`ifndef AXIMM_LINK_DEFS_SVH
`define AXIMM_LINK_DEFS_SVH

// user request fields
`define AXI_ID_W       4
`define AXI_ADDR_W     32
`define AXI_DATA_W     64
`define AXI_STRB_W     8

// follower buffering, one credit per entry
`define RX_FIFO_DEPTH  4

// must hold RX_FIFO_DEPTH
`define CREDIT_W       3

// online only with every bit set
`define XFER_EN_W      4

`endif

// ==== aximm_axi_pkg.sv ====
/*
 * AXI request types for the user-facing channels
 * single-beat write with address and data fused, and read address
 */
`include "aximm_link_defs.svh"

package aximm_axi_pkg;

  //////////////////////////////////////////////////
  // write request, 108 bits
  //////////////////////////////////////////////////
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_ADDR_W-1:0] addr;
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
  } axi_wr_req_t;

  //////////////////////////////////////////////////
  // read address request, 36 bits
  //////////////////////////////////////////////////
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_ADDR_W-1:0] addr;
  } axi_rd_req_t;

endpackage

// ==== aximm_phy_pkg.sv ====
/*
 * PHY lane types
 * word kind opcode, lane word layout, credit return and grant record
 */
`include "aximm_link_defs.svh"

package aximm_phy_pkg;

  // 2'b11 is never driven
  typedef enum logic [1:0] {
    PHY_IDLE  = 2'd0,
    PHY_WRITE = 2'd1,
    PHY_READ  = 2'd2
  } phy_kind_e;

  // data and strb are zero on reads
  typedef struct packed {
    phy_kind_e              kind;
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_ADDR_W-1:0] addr;
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
  } phy_word_t;

  // one-cycle pulses, one per drained entry
  typedef struct packed {
    logic wr;
    logic rd;
  } credit_ret_t;

  // last channel served
  typedef enum logic {
    GRANT_WR = 1'b0,
    GRANT_RD = 1'b1
  } grant_e;

endpackage

// ==== aximm_rx_fifo.sv ====
/*
 * Receive FIFO, first word fall through
 * returns one credit pulse to the leader per drained entry
 */
`timescale 1ns/1ps
`include "aximm_link_defs.svh"

module aximm_rx_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = `RX_FIFO_DEPTH
) (
  input  logic             F_clk_wr,
  input  logic             m_wr_rst_n,
  input  logic             i_push,
  input  logic [WIDTH-1:0] i_data,
  input  logic             i_ready,
  output logic [WIDTH-1:0] o_data,
  output logic             o_valid,
  output logic             o_credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop;
  logic             full;

  assign o_valid = (count != '0);
  assign o_data  = mem[rd_ptr];
  assign pop     = o_valid && i_ready;
  assign full    = (count == CNT_W'(DEPTH));

  always_ff @(posedge F_clk_wr)
  begin
    if (i_push)
      mem[wr_ptr] <= i_data;
  end

  always_ff @(posedge F_clk_wr)
  begin
    if (!m_wr_rst_n)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      o_credit <= 1'b0;
    end
    else
    begin
      if (i_push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (i_push && !pop)
        count <= count + 1'b1;
      else if (pop && !i_push)
        count <= count - 1'b1;
      // one credit back per entry leaving
      o_credit <= pop;
    end
  end

  // credits upstream keep this from happening
  a_no_overflow: assert property (@(posedge F_clk_wr) disable iff (!m_wr_rst_n)
    !(i_push && full));

endmodule

// ==== aximm_phy_decode.sv ====
/*
 * Follower-side PHY word decoder
 * steers each lane word into the write or read receive FIFO
 */
`timescale 1ns/1ps
`include "aximm_link_defs.svh"

module aximm_phy_decode (
  input  logic                        F_clk_wr,
  input  logic                        m_wr_rst_n,
  input  aximm_phy_pkg::phy_word_t    i_phy,
  output logic                        o_wr_push,
  output aximm_axi_pkg::axi_wr_req_t  o_wr_data,
  output logic                        o_rd_push,
  output aximm_axi_pkg::axi_rd_req_t  o_rd_data
);

  import aximm_phy_pkg::*;

  // push strobes
  always_ff @(posedge F_clk_wr)
  begin
    if (!m_wr_rst_n)
    begin
      o_wr_push <= 1'b0;
      o_rd_push <= 1'b0;
    end
    else
    begin
      o_wr_push <= 1'b0;
      o_rd_push <= 1'b0;
      case (i_phy.kind)
        PHY_WRITE: o_wr_push <= 1'b1;
        PHY_READ:  o_rd_push <= 1'b1;
        default:   ;
      endcase
    end
  end

  // payloads follow the same decode
  always_ff @(posedge F_clk_wr)
  begin
    case (i_phy.kind)
      PHY_WRITE:
      begin
        o_wr_data <= '{id: i_phy.id, addr: i_phy.addr, data: i_phy.data, strb: i_phy.strb};
      end
      PHY_READ:
      begin
        o_rd_data <= '{id: i_phy.id, addr: i_phy.addr};
      end
      default: ;
    endcase
  end

  // leader only sends idle, write or read
  a_kind_legal: assert property (@(posedge F_clk_wr) disable iff (!m_wr_rst_n)
    i_phy.kind inside {PHY_IDLE, PHY_WRITE, PHY_READ});

endmodule

// ==== aximm_credit_arb.sv ====
/*
 * Leader-side credit arbiter
 * gates both request channels on link online and per-channel credit,
 * breaks ties round robin and registers one PHY word per cycle
 */
`timescale 1ns/1ps
`include "aximm_link_defs.svh"

module aximm_credit_arb (
  input  logic                        F_clk_wr,
  input  logic                        m_wr_rst_n,
  input  logic [`XFER_EN_W-1:0]       i_transfer_en,
  input  aximm_axi_pkg::axi_wr_req_t  i_wr,
  input  logic                        i_wr_valid,
  input  aximm_axi_pkg::axi_rd_req_t  i_rd,
  input  logic                        i_rd_valid,
  input  aximm_phy_pkg::credit_ret_t  i_credit_ret,
  output logic                        o_wr_ready,
  output logic                        o_rd_ready,
  output aximm_phy_pkg::phy_word_t    o_phy
);

  import aximm_phy_pkg::*;

  logic [`CREDIT_W-1:0]   wr_credit;
  logic [`CREDIT_W-1:0]   rd_credit;
  grant_e                 last_grant;
  logic                   online;
  logic                   wr_can;
  logic                   rd_can;
  logic                   wr_fire;
  logic                   rd_fire;
  phy_kind_e              kind_q;
  logic [`AXI_ID_W-1:0]   id_q;
  logic [`AXI_ADDR_W-1:0] addr_q;
  logic [`AXI_DATA_W-1:0] data_q;
  logic [`AXI_STRB_W-1:0] strb_q;

  function automatic logic [`CREDIT_W-1:0] next_credit(
    input logic [`CREDIT_W-1:0] cur,
    input logic                 take,
    input logic                 give
  );
    logic [`CREDIT_W-1:0] nxt;
    nxt = cur;
    if (take && !give)
      nxt = cur - 1'b1;
    else if (give && !take)
      nxt = cur + 1'b1;
    return nxt;
  endfunction

  //////////////////////////////////////////////////
  // ready rules
  //////////////////////////////////////////////////
  assign online = &i_transfer_en;
  assign wr_can = online && (wr_credit != '0);
  assign rd_can = online && (rd_credit != '0);

  // on a tie the channel not served last wins
  assign o_wr_ready = wr_can && !(rd_can && i_rd_valid && last_grant == GRANT_WR);
  assign o_rd_ready = rd_can && !(wr_can && i_wr_valid && last_grant == GRANT_RD);

  assign wr_fire = i_wr_valid && o_wr_ready;
  assign rd_fire = i_rd_valid && o_rd_ready;

  always_ff @(posedge F_clk_wr)
  begin
    if (!m_wr_rst_n)
    begin
      wr_credit  <= `CREDIT_W'(`RX_FIFO_DEPTH);
      rd_credit  <= `CREDIT_W'(`RX_FIFO_DEPTH);
      last_grant <= GRANT_RD;
      kind_q     <= PHY_IDLE;
    end
    else
    begin
      wr_credit <= next_credit(wr_credit, wr_fire, i_credit_ret.wr);
      rd_credit <= next_credit(rd_credit, rd_fire, i_credit_ret.rd);
      kind_q    <= PHY_IDLE;
      if (wr_fire)
      begin
        last_grant <= GRANT_WR;
        kind_q     <= PHY_WRITE;
      end
      else if (rd_fire)
      begin
        last_grant <= GRANT_RD;
        kind_q     <= PHY_READ;
      end
    end
  end

  // lane payload, meaningful only while kind is not idle
  always_ff @(posedge F_clk_wr)
  begin
    if (wr_fire)
    begin
      id_q   <= i_wr.id;
      addr_q <= i_wr.addr;
      data_q <= i_wr.data;
      strb_q <= i_wr.strb;
    end
    else if (rd_fire)
    begin
      id_q   <= i_rd.id;
      addr_q <= i_rd.addr;
      data_q <= '0;
      strb_q <= '0;
    end
  end

  assign o_phy = '{kind: kind_q, id: id_q, addr: addr_q, data: data_q, strb: strb_q};

  // returns from the follower never overfill a counter
  a_credit_bound: assert property (@(posedge F_clk_wr) disable iff (!m_wr_rst_n)
    (wr_credit <= `RX_FIFO_DEPTH) && (rd_credit <= `RX_FIFO_DEPTH));

endmodule

// ==== aximm_link_top.sv ====
/*
 * AXI-MM link top level
 * leader arbiter and follower decoder joined by the PHY lane,
 * receive FIFOs return credits to the leader
 */
`timescale 1ns/1ps
`include "aximm_link_defs.svh"

module aximm_link_top (
  input  logic                        F_clk_wr,
  input  logic                        m_wr_rst_n,
  input  logic [`XFER_EN_W-1:0]       i_transfer_en,
  input  aximm_axi_pkg::axi_wr_req_t  i_wr,
  input  logic                        i_wr_valid,
  input  aximm_axi_pkg::axi_rd_req_t  i_rd,
  input  logic                        i_rd_valid,
  input  logic                        i_wr_out_ready,
  input  logic                        i_rd_out_ready,
  output logic                        o_wr_ready,
  output logic                        o_rd_ready,
  output aximm_axi_pkg::axi_wr_req_t  o_wr_out,
  output logic                        o_wr_out_valid,
  output aximm_axi_pkg::axi_rd_req_t  o_rd_out,
  output logic                        o_rd_out_valid
);

  import aximm_axi_pkg::*;
  import aximm_phy_pkg::*;

  phy_word_t   phy_word;
  credit_ret_t credit_ret;
  logic        wr_push;
  axi_wr_req_t wr_push_data;
  logic        rd_push;
  axi_rd_req_t rd_push_data;

  //////////////////////////////////////////////////
  // leader
  //////////////////////////////////////////////////
  aximm_credit_arb u_credit_arb (
    .F_clk_wr      (F_clk_wr),
    .m_wr_rst_n    (m_wr_rst_n),
    .i_transfer_en (i_transfer_en),
    .i_wr          (i_wr),
    .i_wr_valid    (i_wr_valid),
    .i_rd          (i_rd),
    .i_rd_valid    (i_rd_valid),
    .i_credit_ret  (credit_ret),
    .o_wr_ready    (o_wr_ready),
    .o_rd_ready    (o_rd_ready),
    .o_phy         (phy_word)
  );

  //////////////////////////////////////////////////
  // follower
  //////////////////////////////////////////////////
  aximm_phy_decode u_phy_decode (
    .F_clk_wr   (F_clk_wr),
    .m_wr_rst_n (m_wr_rst_n),
    .i_phy      (phy_word),
    .o_wr_push  (wr_push),
    .o_wr_data  (wr_push_data),
    .o_rd_push  (rd_push),
    .o_rd_data  (rd_push_data)
  );

  aximm_rx_fifo #(.WIDTH($bits(axi_wr_req_t))) u_wr_fifo (
    .F_clk_wr   (F_clk_wr),
    .m_wr_rst_n (m_wr_rst_n),
    .i_push     (wr_push),
    .i_data     (wr_push_data),
    .i_ready    (i_wr_out_ready),
    .o_data     (o_wr_out),
    .o_valid    (o_wr_out_valid),
    .o_credit   (credit_ret.wr)
  );

  aximm_rx_fifo #(.WIDTH($bits(axi_rd_req_t))) u_rd_fifo (
    .F_clk_wr   (F_clk_wr),
    .m_wr_rst_n (m_wr_rst_n),
    .i_push     (rd_push),
    .i_data     (rd_push_data),
    .i_ready    (i_rd_out_ready),
    .o_data     (o_rd_out),
    .o_valid    (o_rd_out_valid),
    .o_credit   (credit_ret.rd)
  );

endmodule

// ==== tb_aximm_link.sv ====
/*
 * Testbench for the AXI-MM link
 * table-driven write/read traffic with per-channel scoreboards,
 * latency, arbitration, back-pressure and offline checks
 */
`timescale 1ns/1ps
`include "aximm_link_defs.svh"

module tb_aximm_link;

  import aximm_axi_pkg::*;

  localparam logic [1:0] CH_WR   = 2'd0;
  localparam logic [1:0] CH_RD   = 2'd1;
  localparam logic [1:0] CH_BOTH = 2'd2;
  localparam int N_ENTRY = 20;
  localparam int LIMIT   = 20 * N_ENTRY + 200;

  typedef struct packed {
    logic [1:0]            chan;
    logic [7:0]            hold;
    logic [`XFER_EN_W-1:0] xen;
    axi_wr_req_t           req;
  } entry_t;

  logic                  F_clk_wr;
  logic                  m_wr_rst_n;
  logic [`XFER_EN_W-1:0] i_transfer_en;
  axi_wr_req_t           i_wr;
  logic                  i_wr_valid;
  axi_rd_req_t           i_rd;
  logic                  i_rd_valid;
  logic                  i_wr_out_ready;
  logic                  i_rd_out_ready;
  logic                  o_wr_ready;
  logic                  o_rd_ready;
  axi_wr_req_t           o_wr_out;
  logic                  o_wr_out_valid;
  axi_rd_req_t           o_rd_out;
  logic                  o_rd_out_valid;

  entry_t      table_q [N_ENTRY];
  int          n_added = 0;
  logic [31:0] seed = 32'hb44f;
  axi_wr_req_t wr_q [$];
  axi_rd_req_t rd_q [$];
  logic        wr_taken = 1'b0;
  logic        rd_taken = 1'b0;
  logic        last_acc_wr = 1'b0;
  int          wr_lat_edge = -1;
  int          rd_lat_edge = -1;
  int          hold_wr = 0;
  int          hold_rd = 0;
  int          cyc = 0;

  aximm_link_top DUT (.*);

  always #2 F_clk_wr = ~F_clk_wr;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic add_entry(input logic [1:0] chan, input logic [7:0] hold,
                           input logic [`XFER_EN_W-1:0] xen);
    entry_t      e;
    logic [31:0] rnd;
    e.chan     = chan;
    e.hold     = hold;
    e.xen      = xen;
    e.req.id   = n_added[3:0];
    e.req.addr = lcg_next();
    e.req.data = {lcg_next(), lcg_next()};
    rnd        = lcg_next();
    e.req.strb = rnd[7:0];
    table_q[n_added] = e;
    n_added++;
  endtask

  // every input change goes through here on the falling edge
  task automatic next_fall();
    @(negedge F_clk_wr);
    if (hold_wr > 0)
      hold_wr--;
    if (hold_rd > 0)
      hold_rd--;
    i_wr_out_ready = (hold_wr == 0);
    i_rd_out_ready = (hold_rd == 0);
  endtask

  //////////////////////////////////////////////////
  // monitor one ns before each rising edge
  //////////////////////////////////////////////////
  task automatic check_window();
    axi_wr_req_t wexp;
    axi_rd_req_t rexp;
    // lone request shows valid two edges after acceptance
    if (wr_lat_edge >= 0 && (o_wr_out_valid || cyc >= wr_lat_edge))
    begin
      assert (o_wr_out_valid && cyc == wr_lat_edge)
      else report_fail($sformatf("** Error: o_wr_out_valid latency expected edge %h got %h",
                                 wr_lat_edge, cyc));
      wr_lat_edge = -1;
    end
    if (rd_lat_edge >= 0 && (o_rd_out_valid || cyc >= rd_lat_edge))
    begin
      assert (o_rd_out_valid && cyc == rd_lat_edge)
      else report_fail($sformatf("** Error: o_rd_out_valid latency expected edge %h got %h",
                                 rd_lat_edge, cyc));
      rd_lat_edge = -1;
    end
    if (!(&i_transfer_en))
      assert (!o_wr_ready && !o_rd_ready)
      else report_fail("an input ready was high while the link was offline");
    if (wr_q.size() == `RX_FIFO_DEPTH)
      assert (!o_wr_ready)
      else report_fail("write ready was high with every write credit in use");
    if (o_wr_out_valid && i_wr_out_ready)
    begin
      assert (wr_q.size() != 0)
      else report_fail("a write came out that was never accepted");
      wexp = wr_q.pop_front();
      assert (o_wr_out == wexp)
      else report_fail($sformatf("** Error: o_wr_out expected %h got %h", wexp, o_wr_out));
    end
    if (o_rd_out_valid && i_rd_out_ready)
    begin
      assert (rd_q.size() != 0)
      else report_fail("a read came out that was never accepted");
      rexp = rd_q.pop_front();
      assert (o_rd_out == rexp)
      else report_fail($sformatf("** Error: o_rd_out expected %h got %h", rexp, o_rd_out));
    end
    wr_taken = i_wr_valid && o_wr_ready;
    rd_taken = i_rd_valid && o_rd_ready;
    assert (!(wr_taken && rd_taken))
    else report_fail("both channels were accepted in one cycle");
    if (wr_taken)
    begin
      if (wr_q.size() == 0)
        wr_lat_edge = cyc + 3;
      wr_q.push_back(i_wr);
      last_acc_wr = 1'b1;
    end
    if (rd_taken)
    begin
      if (rd_q.size() == 0)
        rd_lat_edge = cyc + 3;
      rd_q.push_back(i_rd);
      last_acc_wr = 1'b0;
    end
  endtask

  always @(negedge F_clk_wr)
  begin
    #1;
    if (m_wr_rst_n)
      check_window();
  end

  always @(posedge F_clk_wr)
  begin
    cyc <= cyc + 1;
    if (cyc >= LIMIT)
    begin
      $display("timeout: the run did not finish within %0d cycles", LIMIT);
      report_fail("stopped on timeout");
    end
  end

  task automatic apply_entry(input int k);
    entry_t e;
    logic   wr_pend;
    logic   rd_pend;
    logic   exp_wr_first;
    logic   first;
    int     n;
    e            = table_q[k];
    wr_pend      = (e.chan != CH_RD);
    rd_pend      = (e.chan != CH_WR);
    exp_wr_first = !last_acc_wr;
    first        = 1'b1;
    n            = 0;
    i_transfer_en = e.xen;
    if (e.hold != 0 && e.chan == CH_RD)
    begin
      hold_rd        = e.hold;
      i_rd_out_ready = 1'b0;
    end
    else if (e.hold != 0)
    begin
      hold_wr        = e.hold;
      i_wr_out_ready = 1'b0;
    end
    i_wr       = e.req;
    i_wr_valid = wr_pend;
    i_rd       = '{id: e.req.id, addr: e.req.addr};
    i_rd_valid = rd_pend;
    while (wr_pend || rd_pend)
    begin
      next_fall();
      n++;
      if (e.chan == CH_BOTH && first && (wr_taken || rd_taken))
      begin
        assert (wr_taken == exp_wr_first)
        else report_fail("on a tie the channel served last was granted again");
        first = 1'b0;
      end
      if (wr_pend && wr_taken)
      begin
        wr_pend    = 1'b0;
        i_wr_valid = 1'b0;
      end
      if (rd_pend && rd_taken)
      begin
        rd_pend    = 1'b0;
        i_rd_valid = 1'b0;
      end
      // bring the link back online after a while
      if (n == 8 && !(&e.xen))
        i_transfer_en = '1;
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial
  begin
    F_clk_wr       = 1'b0;
    m_wr_rst_n     = 1'b0;
    i_transfer_en  = '1;
    i_wr           = '0;
    i_wr_valid     = 1'b0;
    i_rd           = '0;
    i_rd_valid     = 1'b0;
    i_wr_out_ready = 1'b1;
    i_rd_out_ready = 1'b1;

    // lone requests, then ties, then back-pressure, then offline
    add_entry(CH_WR, 8'd0, 4'hf);
    add_entry(CH_RD, 8'd0, 4'hf);
    add_entry(CH_WR, 8'd0, 4'hf);
    add_entry(CH_RD, 8'd0, 4'hf);
    for (int i = 0; i < 4; i++)
      add_entry(CH_BOTH, 8'd0, 4'hf);
    add_entry(CH_WR, 8'd30, 4'hf);
    for (int i = 0; i < 5; i++)
      add_entry(CH_WR, 8'd0, 4'hf);
    add_entry(CH_RD, 8'd0, 4'b1101);
    add_entry(CH_WR, 8'd0, 4'b0111);
    add_entry(CH_BOTH, 8'd0, 4'hf);
    add_entry(CH_RD, 8'd0, 4'hf);
    add_entry(CH_WR, 8'd0, 4'hf);
    add_entry(CH_RD, 8'd5, 4'hf);

    repeat (10) @(posedge F_clk_wr);
    next_fall();
    m_wr_rst_n = 1'b1;
    #1;
    assert (!o_wr_out_valid && !o_rd_out_valid)
    else report_fail("an output valid was high right after reset");
    assert (o_wr_ready && o_rd_ready)
    else report_fail("an input ready was low right after reset");
    next_fall();

    for (int k = 0; k < N_ENTRY; k++)
      apply_entry(k);
    while (wr_q.size() != 0 || rd_q.size() != 0)
      next_fall();
    next_fall();

    $display("test passed");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+.
aximm_axi_pkg.sv
aximm_phy_pkg.sv
aximm_rx_fifo.sv
aximm_phy_decode.sv
aximm_credit_arb.sv
aximm_link_top.sv
tb_aximm_link.sv

// ==== Makefile ====
TOP := tb_aximm_link

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -o sim
	./obj_dir/sim | tee /dev/stderr | grep -q "^test passed$$"

clean:
	rm -rf obj_dir
